/* files.f */
+incdir+logic
logic/ctlPkg.sv
logic/rvIsaPkg.sv
logic/aluDecoder.sv
logic/memBranchDecoder.sv
logic/instrDecoder.sv
testbench/instrDecoderTb.sv

/* logic/aluDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decoder_settings.svh"

module aluDecoder (
    input  rvIsaPkg::instrWord instr,
    input  rvIsaPkg::opClass   opClass,
    output ctlPkg::aluFuncT    aluFunc,
    output ctlPkg::aluSrcT     aluSrc,
    output ctlPkg::immGenT     immGen
);

    logic [`FUNCT3_W-1:0] funct3;
    logic                 regBit30;
    logic                 immBit30;
    logic                 isShift;

    assign funct3   = instr.rType.funct3;
    // bit 30 read as funct7[5] in register forms, funct6[4] in shift immediates
    assign regBit30 = instr.rType.funct7[5];
    assign immBit30 = instr.iType.funct6[4];
    assign isShift  = (funct3 == `F3_SLL) || (funct3 == `F3_SR);

    function automatic ctlPkg::aluFuncT baseFunc(
        input logic [`FUNCT3_W-1:0] f3,
        input logic                 sub,
        input logic                 arith
    );
        case (f3)
            `F3_ADD:  baseFunc = sub ? ctlPkg::Sub : ctlPkg::Add;
            `F3_SLL:  baseFunc = ctlPkg::Sll;
            `F3_SLT:  baseFunc = ctlPkg::Slt;
            `F3_SLTU: baseFunc = ctlPkg::Sltu;
            `F3_XOR:  baseFunc = ctlPkg::Xor;
            `F3_SR:   baseFunc = arith ? ctlPkg::Sra : ctlPkg::Srl;
            `F3_OR:   baseFunc = ctlPkg::Or;
            default:  baseFunc = ctlPkg::And;
        endcase
    endfunction

    // only add, sll and sr exist in the word groups
    function automatic ctlPkg::aluFuncT wordFunc(
        input logic [`FUNCT3_W-1:0] f3,
        input logic                 arith,
        input logic                 imm
    );
        case (f3)
            `F3_ADD: begin
                if (imm)
                    wordFunc = ctlPkg::AddIw;
                else
                    wordFunc = arith ? ctlPkg::SubW : ctlPkg::AddW;
            end
            `F3_SLL: wordFunc = imm ? ctlPkg::SllIw : ctlPkg::SllW;
            `F3_SR: begin
                if (imm)
                    wordFunc = arith ? ctlPkg::SraIw : ctlPkg::SrlIw;
                else
                    wordFunc = arith ? ctlPkg::SraW : ctlPkg::SrlW;
            end
            default: wordFunc = ctlPkg::Unknown;
        endcase
    endfunction

    always_comb begin
        aluFunc = ctlPkg::Unknown;
        aluSrc  = ctlPkg::FromReg;
        immGen  = ctlPkg::NoGen;
        case (opClass)
            rvIsaPkg::OpOp:   aluFunc = baseFunc(funct3, regBit30, regBit30);
            rvIsaPkg::OpOp32: aluFunc = wordFunc(funct3, regBit30, 1'b0);
            rvIsaPkg::OpOpImm, rvIsaPkg::OpOpImm32: begin
                if (opClass == rvIsaPkg::OpOpImm)
                    aluFunc = baseFunc(funct3, 1'b0, immBit30);
                else
                    aluFunc = wordFunc(funct3, immBit30, 1'b1);
                if (aluFunc != ctlPkg::Unknown) begin
                    aluSrc = isShift ? ctlPkg::FromShamt : ctlPkg::FromImm;
                    immGen = isShift ? ctlPkg::NoGen : ctlPkg::GenI;
                end
            end
            rvIsaPkg::OpLoad, rvIsaPkg::OpStore: begin
                aluFunc = ctlPkg::Add;
                aluSrc  = ctlPkg::FromImm;
                immGen  = (opClass == rvIsaPkg::OpLoad) ? ctlPkg::GenI : ctlPkg::GenS;
            end
            rvIsaPkg::OpBranch: begin
                aluFunc = ctlPkg::Branch;
                immGen  = ctlPkg::GenB;
            end
            rvIsaPkg::OpLui, rvIsaPkg::OpAuipc: begin
                aluFunc = ctlPkg::Link;
                aluSrc  = (opClass == rvIsaPkg::OpLui) ? ctlPkg::FromImm : ctlPkg::FromPcAddImm;
                immGen  = ctlPkg::GenU;
            end
            rvIsaPkg::OpJal, rvIsaPkg::OpJalr: begin
                aluFunc = ctlPkg::Link;
                aluSrc  = ctlPkg::FromPcAdd4;
                immGen  = (opClass == rvIsaPkg::OpJal) ? ctlPkg::GenJ : ctlPkg::GenI;
            end
            rvIsaPkg::OpSystem: begin
                aluSrc = ctlPkg::FromCsr;
                case (funct3)
                    `F3_CSRRW, `F3_CSRRWI: aluFunc = ctlPkg::Rs1Pass;
                    `F3_CSRRS, `F3_CSRRSI: aluFunc = ctlPkg::Or;
                    `F3_CSRRC, `F3_CSRRCI: aluFunc = ctlPkg::And;
                    default:               aluFunc = ctlPkg::Unknown;
                endcase
                // zimm lives in the rs1 field
                if (funct3 inside {`F3_CSRRWI, `F3_CSRRSI, `F3_CSRRCI})
                    immGen = ctlPkg::GenCsr;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* logic/ctlPkg.sv */
`default_nettype none

package ctlPkg;

    typedef enum logic [1:0] {
        NoRs    = 2'd0,
        OnlyRs1,
        BothRs
    } regUseT;

    // I-suffixed word ops come from OP_IMM_32
    typedef enum logic [4:0] {
        Unknown = 5'd0,
        Add,
        Sub,
        Xor,
        Or,
        And,
        Slt,
        Sltu,
        Sll,
        Srl,
        Sra,
        AddIw,
        SllIw,
        SrlIw,
        SraIw,
        AddW,
        SubW,
        SllW,
        SrlW,
        SraW,
        Link,
        Branch,
        Rs1Pass
    } aluFuncT;

    typedef enum logic [2:0] {
        FromReg = 3'd0,
        FromImm,
        FromShamt,
        FromPcAddImm,
        FromPcAdd4,
        FromCsr
    } aluSrcT;

    typedef enum logic [2:0] {
        NoGen = 3'd0,
        GenI,
        GenU,
        GenB,
        GenS,
        GenJ,
        GenCsr
    } immGenT;

    typedef enum logic [2:0] {
        SizeZero = 3'd0,
        Size8,
        Size16,
        Size32,
        Size64
    } memSizeT;

    // load result extension, named by the top source bit
    typedef enum logic [2:0] {
        WbNone = 3'd0,
        Sext7,
        Sext15,
        Sext31,
        Zext7,
        Zext15,
        Zext31,
        Full63
    } wbTypeT;

    typedef enum logic [3:0] {
        NoBranch = 4'd0,
        Eq,
        Ne,
        LtS,
        LtU,
        GeS,
        GeU,
        Jal,
        Jalr
    } branchT;

endpackage

`default_nettype wire

/* logic/decoder_settings.svh */
`ifndef DECODER_SETTINGS_SVH
`define DECODER_SETTINGS_SVH

// field widths fixed by the base ISA
`define INSTR_W  32
`define OPCODE_W 7
`define FUNCT3_W 3

// major opcodes
`define OPC_OP        7'b0110011
`define OPC_OP_IMM    7'b0010011
`define OPC_OP_32     7'b0111011
`define OPC_OP_IMM_32 7'b0011011
`define OPC_LOAD      7'b0000011
`define OPC_STORE     7'b0100011
`define OPC_BRANCH    7'b1100011
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_SYSTEM    7'b1110011

// integer ALU group, shared by register and immediate forms
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

// load/store access size, the U forms exist for loads only
`define F3_B  3'b000
`define F3_H  3'b001
`define F3_W  3'b010
`define F3_D  3'b011
`define F3_BU 3'b100
`define F3_HU 3'b101
`define F3_WU 3'b110

// branch compares
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

// Zicsr
`define F3_CSRRW  3'b001
`define F3_CSRRS  3'b010
`define F3_CSRRC  3'b011
`define F3_CSRRWI 3'b101
`define F3_CSRRSI 3'b110
`define F3_CSRRCI 3'b111

`endif

/* logic/instrDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decoder_settings.svh"

module instrDecoder (
    input  logic               clk,
    input  logic               rstN,
    input  logic               instrValid,
    input  rvIsaPkg::instrWord instr,
    output logic               ctlValid,
    output ctlPkg::regUseT     regUse,
    output ctlPkg::aluFuncT    aluFunc,
    output ctlPkg::aluSrcT     aluSrc,
    output ctlPkg::immGenT     immGen,
    output logic               memRead,
    output logic               memWrite,
    output logic               memToReg,
    output logic               regWrite,
    output logic               readCsr,
    output logic               writeCsr,
    output ctlPkg::memSizeT    memSize,
    output ctlPkg::wbTypeT     wbType,
    output ctlPkg::branchT     branchType
);

    rvIsaPkg::opClass opClass;
    ctlPkg::regUseT   classRegUse;
    logic             classRegWrite;
    logic             classCsr;
    ctlPkg::aluFuncT  decAluFunc;
    ctlPkg::aluSrcT   decAluSrc;
    ctlPkg::immGenT   decImmGen;
    logic             decMemRead;
    logic             decMemWrite;
    logic             decMemToReg;
    ctlPkg::memSizeT  decMemSize;
    ctlPkg::wbTypeT   decWbType;
    ctlPkg::branchT   decBranchType;
    logic             memIllegal;

    // single opcode compare, everything below works per class
    always_comb begin
        case (instr.rType.opcode)
            `OPC_OP:        opClass = rvIsaPkg::OpOp;
            `OPC_OP_IMM:    opClass = rvIsaPkg::OpOpImm;
            `OPC_OP_32:     opClass = rvIsaPkg::OpOp32;
            `OPC_OP_IMM_32: opClass = rvIsaPkg::OpOpImm32;
            `OPC_LOAD:      opClass = rvIsaPkg::OpLoad;
            `OPC_STORE:     opClass = rvIsaPkg::OpStore;
            `OPC_BRANCH:    opClass = rvIsaPkg::OpBranch;
            `OPC_LUI:       opClass = rvIsaPkg::OpLui;
            `OPC_AUIPC:     opClass = rvIsaPkg::OpAuipc;
            `OPC_JAL:       opClass = rvIsaPkg::OpJal;
            `OPC_JALR:      opClass = rvIsaPkg::OpJalr;
            `OPC_SYSTEM:    opClass = rvIsaPkg::OpSystem;
            default:        opClass = rvIsaPkg::OpUnknown;
        endcase
    end

    always_comb begin
        case (opClass)
            rvIsaPkg::OpOp, rvIsaPkg::OpOp32, rvIsaPkg::OpStore, rvIsaPkg::OpBranch:
                classRegUse = ctlPkg::BothRs;
            rvIsaPkg::OpOpImm, rvIsaPkg::OpOpImm32, rvIsaPkg::OpLoad, rvIsaPkg::OpJalr:
                classRegUse = ctlPkg::OnlyRs1;
            default:
                classRegUse = ctlPkg::NoRs;
        endcase
    end

    assign classRegWrite = !(opClass inside {rvIsaPkg::OpStore, rvIsaPkg::OpBranch,
                                             rvIsaPkg::OpUnknown});
    assign classCsr      = (opClass == rvIsaPkg::OpSystem);

    aluDecoder uAluDecoder (
        .instr   (instr),
        .opClass (opClass),
        .aluFunc (decAluFunc),
        .aluSrc  (decAluSrc),
        .immGen  (decImmGen)
    );

    memBranchDecoder uMemBranchDecoder (
        .instr      (instr),
        .opClass    (opClass),
        .memRead    (decMemRead),
        .memWrite   (decMemWrite),
        .memToReg   (decMemToReg),
        .memIllegal (memIllegal),
        .memSize    (decMemSize),
        .wbType     (decWbType),
        .branchType (decBranchType)
    );

    always_ff @(posedge clk) begin
        if (!rstN)
            ctlValid <= 1'b0;
        else
            ctlValid <= instrValid;
    end

    // fields hold while idle, a bad load/store width clears them
    always_ff @(posedge clk) begin
        if (!rstN || (instrValid && memIllegal)) begin
            regUse     <= ctlPkg::NoRs;
            aluFunc    <= ctlPkg::Unknown;
            aluSrc     <= ctlPkg::FromReg;
            immGen     <= ctlPkg::NoGen;
            memRead    <= 1'b0;
            memWrite   <= 1'b0;
            memToReg   <= 1'b0;
            regWrite   <= 1'b0;
            readCsr    <= 1'b0;
            writeCsr   <= 1'b0;
            memSize    <= ctlPkg::SizeZero;
            wbType     <= ctlPkg::WbNone;
            branchType <= ctlPkg::NoBranch;
        end else if (instrValid) begin
            regUse     <= classRegUse;
            aluFunc    <= decAluFunc;
            aluSrc     <= decAluSrc;
            immGen     <= decImmGen;
            memRead    <= decMemRead;
            memWrite   <= decMemWrite;
            memToReg   <= decMemToReg;
            regWrite   <= classRegWrite;
            readCsr    <= classCsr;
            writeCsr   <= classCsr;
            memSize    <= decMemSize;
            wbType     <= decWbType;
            branchType <= decBranchType;
        end
    end

    memRdWrExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(memRead && memWrite))
    else $error("memRead and memWrite high together");

endmodule

`default_nettype wire

/* logic/memBranchDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decoder_settings.svh"

module memBranchDecoder (
    input  rvIsaPkg::instrWord instr,
    input  rvIsaPkg::opClass   opClass,
    output logic               memRead,
    output logic               memWrite,
    output logic               memToReg,
    output logic               memIllegal,
    output ctlPkg::memSizeT    memSize,
    output ctlPkg::wbTypeT     wbType,
    output ctlPkg::branchT     branchType
);

    always_comb begin
        memRead    = 1'b0;
        memWrite   = 1'b0;
        memToReg   = 1'b0;
        memIllegal = 1'b0;
        memSize    = ctlPkg::SizeZero;
        wbType     = ctlPkg::WbNone;
        branchType = ctlPkg::NoBranch;
        case (opClass)
            rvIsaPkg::OpLoad: begin
                memRead  = 1'b1;
                memToReg = 1'b1;
                case (instr.iType.funct3)
                    `F3_B: begin
                        memSize = ctlPkg::Size8;
                        wbType  = ctlPkg::Sext7;
                    end
                    `F3_H: begin
                        memSize = ctlPkg::Size16;
                        wbType  = ctlPkg::Sext15;
                    end
                    `F3_W: begin
                        memSize = ctlPkg::Size32;
                        wbType  = ctlPkg::Sext31;
                    end
                    `F3_D: begin
                        memSize = ctlPkg::Size64;
                        wbType  = ctlPkg::Full63;
                    end
                    `F3_BU: begin
                        memSize = ctlPkg::Size8;
                        wbType  = ctlPkg::Zext7;
                    end
                    `F3_HU: begin
                        memSize = ctlPkg::Size16;
                        wbType  = ctlPkg::Zext15;
                    end
                    `F3_WU: begin
                        memSize = ctlPkg::Size32;
                        wbType  = ctlPkg::Zext31;
                    end
                    // top level clears the whole word
                    default: memIllegal = 1'b1;
                endcase
            end
            rvIsaPkg::OpStore: begin
                memWrite = 1'b1;
                case (instr.sType.funct3)
                    `F3_B:   memSize = ctlPkg::Size8;
                    `F3_H:   memSize = ctlPkg::Size16;
                    `F3_W:   memSize = ctlPkg::Size32;
                    `F3_D:   memSize = ctlPkg::Size64;
                    default: memIllegal = 1'b1;
                endcase
            end
            rvIsaPkg::OpBranch: begin
                case (instr.bType.funct3)
                    `F3_BEQ:  branchType = ctlPkg::Eq;
                    `F3_BNE:  branchType = ctlPkg::Ne;
                    `F3_BLT:  branchType = ctlPkg::LtS;
                    `F3_BLTU: branchType = ctlPkg::LtU;
                    `F3_BGE:  branchType = ctlPkg::GeS;
                    `F3_BGEU: branchType = ctlPkg::GeU;
                    default:  branchType = ctlPkg::NoBranch;
                endcase
            end
            rvIsaPkg::OpJal:  branchType = ctlPkg::Jal;
            rvIsaPkg::OpJalr: branchType = ctlPkg::Jalr;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* logic/rvIsaPkg.sv */
`default_nettype none

`include "decoder_settings.svh"

package rvIsaPkg;

    typedef struct packed {
        logic [6:0]           funct7;
        logic [4:0]           rs2;
        logic [4:0]           rs1;
        logic [`FUNCT3_W-1:0] funct3;
        logic [4:0]           rd;
        logic [`OPCODE_W-1:0] opcode;
    } rTypeT;

    // rv64 shift immediates: funct6 on top of a 6-bit shamt
    typedef struct packed {
        logic [5:0]           funct6;
        logic [5:0]           shamt;
        logic [4:0]           rs1;
        logic [`FUNCT3_W-1:0] funct3;
        logic [4:0]           rd;
        logic [`OPCODE_W-1:0] opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0]           immHi;
        logic [4:0]           rs2;
        logic [4:0]           rs1;
        logic [`FUNCT3_W-1:0] funct3;
        logic [4:0]           immLo;
        logic [`OPCODE_W-1:0] opcode;
    } sTypeT;

    typedef struct packed {
        logic                 imm12;
        logic [5:0]           imm10to5;
        logic [4:0]           rs2;
        logic [4:0]           rs1;
        logic [`FUNCT3_W-1:0] funct3;
        logic [3:0]           imm4to1;
        logic                 imm11;
        logic [`OPCODE_W-1:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic [`INSTR_W-`OPCODE_W-6:0] imm;
        logic [4:0]                    rd;
        logic [`OPCODE_W-1:0]          opcode;
    } uTypeT;

    typedef struct packed {
        logic                 imm20;
        logic [9:0]           imm10to1;
        logic                 imm11;
        logic [7:0]           imm19to12;
        logic [4:0]           rd;
        logic [`OPCODE_W-1:0] opcode;
    } jTypeT;

    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        sTypeT sType;
        bTypeT bType;
        uTypeT uType;
        jTypeT jType;
    } instrWord;

    typedef enum logic [3:0] {
        OpUnknown = 4'd0,
        OpOp,
        OpOpImm,
        OpOp32,
        OpOpImm32,
        OpLoad,
        OpStore,
        OpBranch,
        OpLui,
        OpAuipc,
        OpJal,
        OpJalr,
        OpSystem
    } opClass;

endpackage

`default_nettype wire

/* testbench/instrDecoderTb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decoder_settings.svh"

module instrDecoderTb;

    typedef struct packed {
        ctlPkg::regUseT  regUse;
        ctlPkg::aluFuncT aluFunc;
        ctlPkg::aluSrcT  aluSrc;
        ctlPkg::immGenT  immGen;
        logic            memRead;
        logic            memWrite;
        logic            memToReg;
        logic            regWrite;
        logic            readCsr;
        logic            writeCsr;
        ctlPkg::memSizeT memSize;
        ctlPkg::wbTypeT  wbType;
        ctlPkg::branchT  branchType;
    } ctlFieldsT;

    logic                clk;
    logic                rstN;
    logic                instrValid;
    logic [`INSTR_W-1:0] instr;
    logic                ctlValid;
    ctlPkg::regUseT      regUse;
    ctlPkg::aluFuncT     aluFunc;
    ctlPkg::aluSrcT      aluSrc;
    ctlPkg::immGenT      immGen;
    logic                memRead;
    logic                memWrite;
    logic                memToReg;
    logic                regWrite;
    logic                readCsr;
    logic                writeCsr;
    ctlPkg::memSizeT     memSize;
    ctlPkg::wbTypeT      wbType;
    ctlPkg::branchT      branchType;

    ctlFieldsT            expFields;
    logic                 expValid;
    logic                 checkOn;
    logic [31:0]          rngState;
    int                   failCount;
    string                testName;
    logic [`OPCODE_W-1:0] opcodeList [16];

    instrDecoder u_dut (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .ctlValid   (ctlValid),
        .regUse     (regUse),
        .aluFunc    (aluFunc),
        .aluSrc     (aluSrc),
        .immGen     (immGen),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .memToReg   (memToReg),
        .regWrite   (regWrite),
        .readCsr    (readCsr),
        .writeCsr   (writeCsr),
        .memSize    (memSize),
        .wbType     (wbType),
        .branchType (branchType)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // fixed register fields, bit 30 and funct3 chosen by caller
    function automatic logic [`INSTR_W-1:0] makeInstr(
        input logic [`OPCODE_W-1:0] opc,
        input logic [`FUNCT3_W-1:0] f3,
        input logic                 bit30
    );
        return {1'b0, bit30, 5'b00011, 5'd7, 5'd9, f3, 5'd5, opc};
    endfunction

    function automatic ctlFieldsT refModel(input logic [`INSTR_W-1:0] w);
        ctlFieldsT            e;
        logic [`OPCODE_W-1:0] opc;
        logic [`FUNCT3_W-1:0] f3;
        logic                 b30;
        logic                 isReg;
        logic                 shift;
        e     = '0;
        opc   = w[6:0];
        f3    = w[14:12];
        b30   = w[30];
        isReg = (opc == `OPC_OP) || (opc == `OPC_OP_32);
        shift = (f3 == `F3_SLL) || (f3 == `F3_SR);
        case (opc)
            `OPC_OP, `OPC_OP_IMM: begin
                e.regUse   = isReg ? ctlPkg::BothRs : ctlPkg::OnlyRs1;
                e.regWrite = 1'b1;
                case (f3)
                    `F3_ADD:  e.aluFunc = (isReg && b30) ? ctlPkg::Sub : ctlPkg::Add;
                    `F3_SLL:  e.aluFunc = ctlPkg::Sll;
                    `F3_SLT:  e.aluFunc = ctlPkg::Slt;
                    `F3_SLTU: e.aluFunc = ctlPkg::Sltu;
                    `F3_XOR:  e.aluFunc = ctlPkg::Xor;
                    `F3_SR:   e.aluFunc = b30 ? ctlPkg::Sra : ctlPkg::Srl;
                    `F3_OR:   e.aluFunc = ctlPkg::Or;
                    default:  e.aluFunc = ctlPkg::And;
                endcase
                if (!isReg) begin
                    e.aluSrc = shift ? ctlPkg::FromShamt : ctlPkg::FromImm;
                    e.immGen = shift ? ctlPkg::NoGen : ctlPkg::GenI;
                end
            end
            `OPC_OP_32, `OPC_OP_IMM_32: begin
                e.regUse   = isReg ? ctlPkg::BothRs : ctlPkg::OnlyRs1;
                e.regWrite = 1'b1;
                if (f3 == `F3_ADD)
                    e.aluFunc = !isReg ? ctlPkg::AddIw : (b30 ? ctlPkg::SubW : ctlPkg::AddW);
                else if (f3 == `F3_SLL)
                    e.aluFunc = isReg ? ctlPkg::SllW : ctlPkg::SllIw;
                else if (f3 == `F3_SR && isReg)
                    e.aluFunc = b30 ? ctlPkg::SraW : ctlPkg::SrlW;
                else if (f3 == `F3_SR)
                    e.aluFunc = b30 ? ctlPkg::SraIw : ctlPkg::SrlIw;
                if (!isReg && e.aluFunc != ctlPkg::Unknown) begin
                    e.aluSrc = shift ? ctlPkg::FromShamt : ctlPkg::FromImm;
                    e.immGen = shift ? ctlPkg::NoGen : ctlPkg::GenI;
                end
            end
            `OPC_LOAD: begin
                // 3'b111 has no load, whole word stays zero
                if (f3 != 3'b111) begin
                    e.regUse   = ctlPkg::OnlyRs1;
                    e.regWrite = 1'b1;
                    e.aluFunc  = ctlPkg::Add;
                    e.aluSrc   = ctlPkg::FromImm;
                    e.immGen   = ctlPkg::GenI;
                    e.memRead  = 1'b1;
                    e.memToReg = 1'b1;
                    e.memSize  = ctlPkg::memSizeT'({1'b0, f3[1:0]} + 3'd1);
                    if (f3 == `F3_D)
                        e.wbType = ctlPkg::Full63;
                    else
                        e.wbType = ctlPkg::wbTypeT'({1'b0, f3[1:0]} + 3'd1 + (f3[2] ? 3'd3 : 3'd0));
                end
            end
            `OPC_STORE: begin
                if (!f3[2]) begin
                    e.regUse   = ctlPkg::BothRs;
                    e.aluFunc  = ctlPkg::Add;
                    e.aluSrc   = ctlPkg::FromImm;
                    e.immGen   = ctlPkg::GenS;
                    e.memWrite = 1'b1;
                    e.memSize  = ctlPkg::memSizeT'({1'b0, f3[1:0]} + 3'd1);
                end
            end
            `OPC_BRANCH: begin
                e.regUse  = ctlPkg::BothRs;
                e.aluFunc = ctlPkg::Branch;
                e.immGen  = ctlPkg::GenB;
                case (f3)
                    `F3_BEQ:  e.branchType = ctlPkg::Eq;
                    `F3_BNE:  e.branchType = ctlPkg::Ne;
                    `F3_BLT:  e.branchType = ctlPkg::LtS;
                    `F3_BGE:  e.branchType = ctlPkg::GeS;
                    `F3_BLTU: e.branchType = ctlPkg::LtU;
                    `F3_BGEU: e.branchType = ctlPkg::GeU;
                    default:  e.branchType = ctlPkg::NoBranch;
                endcase
            end
            `OPC_LUI, `OPC_AUIPC: begin
                e.regWrite = 1'b1;
                e.aluFunc  = ctlPkg::Link;
                e.aluSrc   = (opc == `OPC_LUI) ? ctlPkg::FromImm : ctlPkg::FromPcAddImm;
                e.immGen   = ctlPkg::GenU;
            end
            `OPC_JAL, `OPC_JALR: begin
                e.regUse     = (opc == `OPC_JALR) ? ctlPkg::OnlyRs1 : ctlPkg::NoRs;
                e.regWrite   = 1'b1;
                e.aluFunc    = ctlPkg::Link;
                e.aluSrc     = ctlPkg::FromPcAdd4;
                e.immGen     = (opc == `OPC_JAL) ? ctlPkg::GenJ : ctlPkg::GenI;
                e.branchType = (opc == `OPC_JAL) ? ctlPkg::Jal : ctlPkg::Jalr;
            end
            `OPC_SYSTEM: begin
                e.regWrite = 1'b1;
                e.readCsr  = 1'b1;
                e.writeCsr = 1'b1;
                e.aluSrc   = ctlPkg::FromCsr;
                // low two bits pick write, set or clear
                case (f3[1:0])
                    2'b01:   e.aluFunc = ctlPkg::Rs1Pass;
                    2'b10:   e.aluFunc = ctlPkg::Or;
                    2'b11:   e.aluFunc = ctlPkg::And;
                    default: e.aluFunc = ctlPkg::Unknown;
                endcase
                if (f3[2] && f3[1:0] != 2'b00)
                    e.immGen = ctlPkg::GenCsr;
            end
            default: ;
        endcase
        return e;
    endfunction

    // expected outputs, one instruction deep
    always @(posedge clk) begin
        if (!rstN) begin
            expFields <= '0;
            expValid  <= 1'b0;
            checkOn   <= 1'b1;
        end else begin
            expValid <= instrValid;
            if (instrValid)
                expFields <= refModel(instr);
        end
    end

    task automatic reportMismatch(input string check, input logic [31:0] expVal,
                                  input logic [31:0] actVal);
        failCount++;
        $display("FAILED %s %s expected %0h actual %0h", testName, check, expVal, actVal);
        $display(">>> FAIL");
        $fatal(1, "stopping at first mismatch");
    endtask

    ctlValidCheck: assert property (@(posedge clk) checkOn |-> ctlValid == expValid)
        else reportMismatch("ctlValid", $sampled(expValid), $sampled(ctlValid));
    regUseCheck: assert property (@(posedge clk) checkOn |-> regUse == expFields.regUse)
        else reportMismatch("regUse", $sampled(expFields.regUse), $sampled(regUse));
    aluFuncCheck: assert property (@(posedge clk) checkOn |-> aluFunc == expFields.aluFunc)
        else reportMismatch("aluFunc", $sampled(expFields.aluFunc), $sampled(aluFunc));
    aluSrcCheck: assert property (@(posedge clk) checkOn |-> aluSrc == expFields.aluSrc)
        else reportMismatch("aluSrc", $sampled(expFields.aluSrc), $sampled(aluSrc));
    immGenCheck: assert property (@(posedge clk) checkOn |-> immGen == expFields.immGen)
        else reportMismatch("immGen", $sampled(expFields.immGen), $sampled(immGen));
    memReadCheck: assert property (@(posedge clk) checkOn |-> memRead == expFields.memRead)
        else reportMismatch("memRead", $sampled(expFields.memRead), $sampled(memRead));
    memWriteCheck: assert property (@(posedge clk) checkOn |-> memWrite == expFields.memWrite)
        else reportMismatch("memWrite", $sampled(expFields.memWrite), $sampled(memWrite));
    memToRegCheck: assert property (@(posedge clk) checkOn |-> memToReg == expFields.memToReg)
        else reportMismatch("memToReg", $sampled(expFields.memToReg), $sampled(memToReg));
    regWriteCheck: assert property (@(posedge clk) checkOn |-> regWrite == expFields.regWrite)
        else reportMismatch("regWrite", $sampled(expFields.regWrite), $sampled(regWrite));
    readCsrCheck: assert property (@(posedge clk) checkOn |-> readCsr == expFields.readCsr)
        else reportMismatch("readCsr", $sampled(expFields.readCsr), $sampled(readCsr));
    writeCsrCheck: assert property (@(posedge clk) checkOn |-> writeCsr == expFields.writeCsr)
        else reportMismatch("writeCsr", $sampled(expFields.writeCsr), $sampled(writeCsr));
    memSizeCheck: assert property (@(posedge clk) checkOn |-> memSize == expFields.memSize)
        else reportMismatch("memSize", $sampled(expFields.memSize), $sampled(memSize));
    wbTypeCheck: assert property (@(posedge clk) checkOn |-> wbType == expFields.wbType)
        else reportMismatch("wbType", $sampled(expFields.wbType), $sampled(wbType));
    branchCheck: assert property (@(posedge clk) checkOn |-> branchType == expFields.branchType)
        else reportMismatch("branchType", $sampled(expFields.branchType), $sampled(branchType));

    task automatic applyInstr(input logic [`INSTR_W-1:0] w, input logic valid);
        @(posedge clk);
        #0.5;
        instrValid = valid;
        instr      = w;
    endtask

    task automatic waitCtlLevel(input logic level, input int limit);
        int   n;
        logic seen;
        n    = 0;
        seen = (ctlValid === level);
        while (!seen && n < limit) begin
            @(posedge clk);
            #1;
            seen = (ctlValid === level);
            n++;
        end
        if (!seen) begin
            $display("timeout: ctlValid did not reach %0b within %0d cycles", level, limit);
            $display(">>> FAIL");
            $fatal(1, "wait timed out");
        end
    endtask

    initial begin
        int                  i;
        int                  op;
        int                  f3;
        int                  b;
        logic [`INSTR_W-1:0] w;
        clk        = 1'b0;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        checkOn    = 1'b0;
        failCount  = 0;
        rngState   = 32'hb6c1a26c;
        testName   = "reset";
        opcodeList = '{`OPC_OP, `OPC_OP_IMM, `OPC_OP_32, `OPC_OP_IMM_32, `OPC_LOAD,
                       `OPC_STORE, `OPC_BRANCH, `OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR,
                       `OPC_SYSTEM, 7'b0000000, 7'b1111111, 7'b0001111, 7'b0101111};

        // a valid strobe inside reset must not leak through
        @(posedge clk);
        #0.5;
        instrValid = 1'b1;
        instr      = makeInstr(`OPC_LUI, 3'b000, 1'b0);
        repeat (2) @(posedge clk);
        #0.5;
        rstN       = 1'b1;
        instrValid = 1'b0;
        applyInstr('0, 1'b0);
        applyInstr('0, 1'b0);

        testName = "sweep";
        for (op = 0; op < 16; op++) begin
            for (f3 = 0; f3 < 8; f3++) begin
                for (b = 0; b < 2; b++) begin
                    rngState = xorshift32(rngState);
                    applyInstr(makeInstr(opcodeList[op], f3[2:0], b[0]), 1'b1);
                    applyInstr(rngState, 1'b0);
                    waitCtlLevel(1'b1, 4);
                    waitCtlLevel(1'b0, 4);
                end
            end
        end

        testName = "burst";
        for (op = 0; op < 16; op++) begin
            for (f3 = 0; f3 < 8; f3++)
                applyInstr(makeInstr(opcodeList[op], f3[2:0], op[0]), 1'b1);
        end
        applyInstr('0, 1'b0);
        waitCtlLevel(1'b0, 4);

        testName = "random";
        for (i = 0; i < 800; i++) begin
            rngState = xorshift32(rngState);
            w        = rngState;
            rngState = xorshift32(rngState);
            w[6:0]   = opcodeList[rngState[3:0]];
            applyInstr(w, rngState[9:8] != 2'b00);
        end
        applyInstr('0, 1'b0);
        waitCtlLevel(1'b0, 4);
        applyInstr('0, 1'b0);

        if (failCount == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire
